/* source/arcade_pkg.sv */
//////////////////////////////////////////////////////////////////////
// arcade glue package
// bus, settings, pad and video structs plus register map and
// controller constants shared by the glue blocks
//////////////////////////////////////////////////////////////////////

package arcade_pkg;

    // apb master to slave
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // apb slave to master
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // dip word as the game expects it
    typedef struct packed {
        logic       demo_sounds;
        logic       zero_hi;
        logic [1:0] lives;
        logic [5:0] zero_mid;
        logic [2:0] difficulty;
        logic [2:0] bonus;
    } dips_t;

    // external controller settings
    typedef struct packed {
        logic [4:0] cont_type;
        logic [1:0] assignment;
        logic       ena;
        logic       blank_screen;
    } snac_cfg_t;

    // one external pad, stick x in [7:0], stick y in [15:8]
    typedef struct packed {
        logic [15:0] btn;
        logic [31:0] stick;
    } pad_t;

    // inputs seen by the game
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic fire;
        logic start;
        logic coin;
    } controls_t;

    // core video, red in the top nibble
    typedef struct packed {
        logic [11:0] rgb12;
        logic        hblank;
        logic        vblank;
        logic        hs;
        logic        vs;
    } video_in_t;

    typedef struct packed {
        logic [23:0] rgb24;
        logic        de;
        logic        hs;
        logic        vs;
    } video_out_t;

    //////////////////////////////////////////////////////////////////////
    // register map
    //////////////////////////////////////////////////////////////////////
    localparam logic [7:0] REG_LIVES      = 8'h00;
    localparam logic [7:0] REG_DIFFICULTY = 8'h04;
    localparam logic [7:0] REG_BONUS      = 8'h08;
    localparam logic [7:0] REG_DEMO       = 8'h0C;
    localparam logic [7:0] REG_SNAC       = 8'h10;
    localparam logic [7:0] REG_RESET      = 8'h14;

    // pad button bit positions
    localparam int KEY_UP    = 0;
    localparam int KEY_DOWN  = 1;
    localparam int KEY_LEFT  = 2;
    localparam int KEY_RIGHT = 3;
    localparam int KEY_FIRE  = 4;
    localparam int KEY_COIN  = 14;
    localparam int KEY_START = 15;

    // stick thresholds, idle sits near 0x7f
    localparam logic [7:0] ANALOG_LOW  = 8'h40;
    localparam logic [7:0] ANALOG_HIGH = 8'hC0;

    // controller types with analog sticks
    localparam logic [4:0] SNAC_ANALOG_A = 5'h12;
    localparam logic [4:0] SNAC_ANALOG_B = 5'h13;

endpackage

/* source/cfg_apb_regs.sv */
//////////////////////////////////////////////////////////////////////
// configuration registers on apb
// holds dip and external controller settings, issues soft reset
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cfg_apb_regs
    import arcade_pkg::*;
(
    input  logic      clk_74a,
    input  logic      reset,
    input  apb_req_t  apb_req,
    output apb_rsp_t  apb_rsp,
    output dips_t     dips,
    output snac_cfg_t snac,
    output logic      reset_req
);

    // stored fields
    logic [1:0] lives_q;
    logic [2:0] difficulty_q;
    logic [2:0] bonus_q;
    logic       demo_q;
    snac_cfg_t  snac_q;
    logic       reset_req_q;

    logic        wr_access;
    logic [31:0] rdata;

    // access phase, pready is tied high so this is the last cycle
    assign wr_access = apb_req.psel & apb_req.penable & apb_req.pwrite;

    //////////////////////////////////////////////////////////////////////
    // write side
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_74a) begin
        if (reset) begin
            lives_q      <= '0;
            difficulty_q <= '0;
            bonus_q      <= '0;
            demo_q       <= 1'b0;
            snac_q       <= '0;
            reset_req_q  <= 1'b0;
        end else begin
            // one cycle strobe unless a reset write lands
            reset_req_q <= 1'b0;
            if (wr_access) begin
                case (apb_req.paddr)
                    REG_LIVES:      lives_q      <= apb_req.pwdata[1:0];
                    REG_DIFFICULTY: difficulty_q <= apb_req.pwdata[2:0];
                    REG_BONUS:      bonus_q      <= apb_req.pwdata[2:0];
                    REG_DEMO:       demo_q       <= apb_req.pwdata[0];
                    REG_SNAC: begin
                        snac_q.cont_type    <= apb_req.pwdata[4:0];
                        snac_q.assignment   <= apb_req.pwdata[9:8];
                        snac_q.ena          <= apb_req.pwdata[16];
                        snac_q.blank_screen <= apb_req.pwdata[17];
                    end
                    REG_RESET:      reset_req_q  <= 1'b1;
                    // unknown offsets dropped
                    default: ;
                endcase
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read side
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        rdata = '0;
        case (apb_req.paddr)
            REG_LIVES:      rdata[1:0] = lives_q;
            REG_DIFFICULTY: rdata[2:0] = difficulty_q;
            REG_BONUS:      rdata[2:0] = bonus_q;
            REG_DEMO:       rdata[0]   = demo_q;
            REG_SNAC: begin
                rdata[4:0] = snac_q.cont_type;
                rdata[9:8] = snac_q.assignment;
                rdata[16]  = snac_q.ena;
                rdata[17]  = snac_q.blank_screen;
            end
            // reset command and holes read back zero
            default:        rdata = '0;
        endcase
    end

    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = 1'b0;

    // dip word layout for the game
    always_comb begin
        dips.demo_sounds = demo_q;
        dips.zero_hi     = 1'b0;
        dips.lives       = lives_q;
        dips.zero_mid    = '0;
        dips.difficulty  = difficulty_q;
        dips.bonus       = bonus_q;
    end

    assign snac      = snac_q;
    assign reset_req = reset_req_q;

endmodule

/* source/input_router.sv */
//////////////////////////////////////////////////////////////////////
// player 1 input router
// picks console or external pad, maps analog sticks onto the d-pad
// and flags the coin button release
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module input_router
    import arcade_pkg::*;
(
    input  logic        clk_74a,
    input  logic        reset,
    input  snac_cfg_t   snac,
    input  logic [15:0] cont1_key,
    input  pad_t        snac_p1,
    input  pad_t        snac_p2,
    output controls_t   controls,
    output logic        coin_release
);

    logic        snac_off;
    logic        snac_analog;
    logic [15:0] p1_map;
    logic [15:0] p2_map;
    logic [15:0] sel_map;

    // registered button map and coin history
    logic [15:0] key_map_q;
    logic        coin_prev_q;

    // swap the d-pad for stick thresholds on analog pads
    function automatic logic [15:0] map_pad(input pad_t pad, input logic analog);
        logic [15:0] res;
        logic [7:0]  stick_x;
        logic [7:0]  stick_y;
        res     = pad.btn;
        stick_x = pad.stick[7:0];
        stick_y = pad.stick[15:8];
        if (analog) begin
            res[KEY_UP]    = stick_y < ANALOG_LOW;
            res[KEY_DOWN]  = stick_y > ANALOG_HIGH;
            res[KEY_LEFT]  = stick_x < ANALOG_LOW;
            res[KEY_RIGHT] = stick_x > ANALOG_HIGH;
        end
        return res;
    endfunction

    assign snac_off    = (snac.cont_type == 5'h00) || !snac.ena;
    assign snac_analog = (snac.cont_type == SNAC_ANALOG_A) ||
                         (snac.cont_type == SNAC_ANALOG_B);

    assign p1_map = map_pad(snac_p1, snac_analog);
    assign p2_map = map_pad(snac_p2, snac_analog);

    //////////////////////////////////////////////////////////////////////
    // source select
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        if (snac_off) begin
            sel_map = cont1_key;
        end else begin
            case (snac.assignment)
                2'd0:    sel_map = p1_map;
                // external pad goes to player 2, console keeps player 1
                2'd1:    sel_map = cont1_key;
                2'd2:    sel_map = p1_map;
                default: sel_map = p2_map;
            endcase
        end
    end

    always_ff @(posedge clk_74a) begin
        if (reset) begin
            key_map_q   <= '0;
            coin_prev_q <= 1'b0;
        end else begin
            key_map_q   <= sel_map;
            coin_prev_q <= key_map_q[KEY_COIN];
        end
    end

    // game view of the map, coin still raw
    always_comb begin
        controls.up    = key_map_q[KEY_UP];
        controls.down  = key_map_q[KEY_DOWN];
        controls.left  = key_map_q[KEY_LEFT];
        controls.right = key_map_q[KEY_RIGHT];
        controls.fire  = key_map_q[KEY_FIRE];
        controls.start = key_map_q[KEY_START];
        controls.coin  = key_map_q[KEY_COIN];
    end

    // falling edge of the registered coin bit
    assign coin_release = coin_prev_q & ~key_map_q[KEY_COIN];

endmodule

/* source/hold_timer.sv */
//////////////////////////////////////////////////////////////////////
// hold timer
// turns a one cycle trigger into a fixed length active window
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module hold_timer #(
    parameter int unsigned HOLD_CYCLES = 16
) (
    input  logic clk_74a,
    input  logic reset,
    input  logic trigger,
    output logic active
);

    // wide enough to hold the full length
    localparam int unsigned CNT_W = $clog2(HOLD_CYCLES + 1);

    logic [CNT_W-1:0] count_q;
    logic             busy;

    assign busy = count_q != '0;

    always_ff @(posedge clk_74a) begin
        if (reset) begin
            count_q <= '0;
        end else if (busy) begin
            // retrigger ignored while counting
            count_q <= count_q - 1'b1;
        end else if (trigger) begin
            count_q <= CNT_W'(HOLD_CYCLES);
        end
    end

    // high from the cycle after the trigger for HOLD_CYCLES cycles
    assign active = busy;

endmodule

/* source/video_formatter.sv */
//////////////////////////////////////////////////////////////////////
// video formatter
// blanks and widens core colour to 24 bits, builds data enable
// and one cycle sync pulses
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module video_formatter
    import arcade_pkg::*;
(
    input  logic       clk_74a,
    input  logic       reset,
    input  snac_cfg_t  snac,
    input  video_in_t  video_in,
    output video_out_t video_out
);

    logic       blank;
    logic       kill_rgb;
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;

    // output stage
    logic [23:0] rgb_q;
    logic        de_q;
    logic        hs_q;
    logic        vs_q;

    // sync history for edge detect
    logic hs_prev_q;
    logic vs_prev_q;

    assign blank    = video_in.hblank | video_in.vblank;
    // screen blank only applies with the external adapter on
    assign kill_rgb = blank | (snac.blank_screen & snac.ena);

    assign red   = video_in.rgb12[11:8];
    assign green = video_in.rgb12[7:4];
    assign blue  = video_in.rgb12[3:0];

    //////////////////////////////////////////////////////////////////////
    // colour path
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_74a) begin
        if (kill_rgb) begin
            rgb_q <= '0;
        end else begin
            // nibble repeat keeps full scale at 0xff
            rgb_q <= {red, red, green, green, blue, blue};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // timing path
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_74a) begin
        if (reset) begin
            de_q      <= 1'b0;
            hs_q      <= 1'b0;
            vs_q      <= 1'b0;
            hs_prev_q <= 1'b0;
            vs_prev_q <= 1'b0;
        end else begin
            de_q      <= ~blank;
            // rising edges only
            hs_q      <= video_in.hs & ~hs_prev_q;
            vs_q      <= video_in.vs & ~vs_prev_q;
            hs_prev_q <= video_in.hs;
            vs_prev_q <= video_in.vs;
        end
    end

    assign video_out.rgb24 = rgb_q;
    assign video_out.de    = de_q;
    assign video_out.hs    = hs_q;
    assign video_out.vs    = vs_q;

endmodule

/* source/arcade_core_top.sv */
//////////////////////////////////////////////////////////////////////
// arcade core glue top
// config registers, player 1 input routing, coin and reset
// stretching, and video formatting on one clock
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module arcade_core_top
    import arcade_pkg::*;
#(
    parameter int unsigned RESET_HOLD_CYCLES = 64,
    parameter int unsigned COIN_HOLD_CYCLES  = 16
) (
    input  logic        clk_74a,
    input  logic        reset,
    input  apb_req_t    apb_req,
    output apb_rsp_t    apb_rsp,
    input  logic [15:0] cont1_key,
    input  pad_t        snac_p1,
    input  pad_t        snac_p2,
    input  video_in_t   video_in,
    output video_out_t  video_out,
    output dips_t       dips,
    output controls_t   game_controls,
    output logic        core_reset
);

    snac_cfg_t snac;
    logic      reset_req;
    controls_t raw_controls;
    logic      coin_release;
    logic      coin_active;
    logic      reset_active;

    //////////////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////////////
    cfg_apb_regs i_cfg_apb_regs (
        .clk_74a   (clk_74a),
        .reset     (reset),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .dips      (dips),
        .snac      (snac),
        .reset_req (reset_req)
    );

    // soft reset stretch
    hold_timer #(
        .HOLD_CYCLES (RESET_HOLD_CYCLES)
    ) i_reset_timer (
        .clk_74a (clk_74a),
        .reset   (reset),
        .trigger (reset_req),
        .active  (reset_active)
    );

    // game reset covers both external and soft reset
    assign core_reset = reset | reset_active;

    //////////////////////////////////////////////////////////////////////
    // inputs
    //////////////////////////////////////////////////////////////////////
    input_router i_input_router (
        .clk_74a      (clk_74a),
        .reset        (reset),
        .snac         (snac),
        .cont1_key    (cont1_key),
        .snac_p1      (snac_p1),
        .snac_p2      (snac_p2),
        .controls     (raw_controls),
        .coin_release (coin_release)
    );

    // coin seen by the game is a stretched pulse after release
    hold_timer #(
        .HOLD_CYCLES (COIN_HOLD_CYCLES)
    ) i_coin_timer (
        .clk_74a (clk_74a),
        .reset   (reset),
        .trigger (coin_release),
        .active  (coin_active)
    );

    always_comb begin
        game_controls      = raw_controls;
        game_controls.coin = coin_active;
    end

    //////////////////////////////////////////////////////////////////////
    // video
    //////////////////////////////////////////////////////////////////////
    video_formatter i_video_formatter (
        .clk_74a   (clk_74a),
        .reset     (reset),
        .snac      (snac),
        .video_in  (video_in),
        .video_out (video_out)
    );

endmodule

/* testbench/tb_arcade_core.sv */
//////////////////////////////////////////////////////////////////////
// testbench for the arcade glue top
// random apb, pad and video stimulus checked every cycle against
// a cycle model of registers, routing, hold timers and video
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_arcade_core
    import arcade_pkg::*;
();

    localparam int RESET_HOLD_CYCLES = 64;
    localparam int COIN_HOLD_CYCLES  = 16;

    // test sizes
    localparam int N_REG  = 40;
    localparam int N_CFG  = 24;
    localparam int N_PAD  = 20;
    localparam int N_VCFG = 6;
    localparam int N_VID  = 40;

    // cycles per test, apb transfers take two cycles each
    localparam int T_RESET = 8;
    localparam int T_REGS  = N_REG * 8 + 2;
    localparam int T_ROUTE = N_CFG * (N_PAD + 2);
    localparam int T_COIN  = 2 + 2 * COIN_HOLD_CYCLES + 3 + COIN_HOLD_CYCLES + 20;
    localparam int T_SOFT  = 2 + RESET_HOLD_CYCLES + 8 + 3;
    localparam int T_VIDEO = N_VCFG * (N_VID + 2) + 4;
    localparam int TIMEOUT_CYCLES = 2 * (T_RESET + T_REGS + T_ROUTE + T_COIN + T_SOFT + T_VIDEO);

    logic        clk_74a = 1'b0;
    logic        reset;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic [15:0] cont1_key;
    pad_t        snac_p1;
    pad_t        snac_p2;
    video_in_t   video_in;
    video_out_t  video_out;
    dips_t       dips;
    controls_t   game_controls;
    logic        core_reset;

    integer seed;
    int     errors;
    int     cycle_count;
    logic   checks_on;

    // model state
    logic [1:0]  m_lives;
    logic [2:0]  m_diff;
    logic [2:0]  m_bonus;
    logic        m_demo;
    snac_cfg_t   m_snac;
    logic        m_reset_req;
    logic [15:0] m_key_map;
    logic        m_coin_prev;
    int          m_coin_cnt;
    int          m_reset_cnt;
    logic [23:0] m_rgb;
    logic        m_de;
    logic        m_hs;
    logic        m_vs;
    logic        m_hs_prev;
    logic        m_vs_prev;

    arcade_core_top i_dut (
        .clk_74a       (clk_74a),
        .reset         (reset),
        .apb_req       (apb_req),
        .apb_rsp       (apb_rsp),
        .cont1_key     (cont1_key),
        .snac_p1       (snac_p1),
        .snac_p2       (snac_p2),
        .video_in      (video_in),
        .video_out     (video_out),
        .dips          (dips),
        .game_controls (game_controls),
        .core_reset    (core_reset)
    );

    always #20 clk_74a = ~clk_74a;

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////
    task automatic check(input logic [63:0] expected, input logic [63:0] actual,
                         input string what);
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t ns: %s expected %0h got %0h", $time, what, expected, actual);
        end
    endtask

    // stimulus phase, just after the rising edge
    task automatic next_cycle();
        @(posedge clk_74a);
        #2;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b1;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        next_cycle();
        apb_req.penable = 1'b1;
        next_cycle();
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
        apb_req.paddr   = addr;
        next_cycle();
        apb_req.penable = 1'b1;
        // sample mid access phase
        @(negedge clk_74a);
        data = apb_rsp.prdata;
        next_cycle();
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    function automatic logic [7:0] pick_reg(int idx);
        case (idx)
            0:       return REG_LIVES;
            1:       return REG_DIFFICULTY;
            2:       return REG_BONUS;
            3:       return REG_DEMO;
            default: return REG_SNAC;
        endcase
    endfunction

    // bits of each register that hold state
    function automatic logic [31:0] field_mask(logic [7:0] addr);
        case (addr)
            REG_LIVES:                 return 32'h0000_0003;
            REG_DIFFICULTY, REG_BONUS: return 32'h0000_0007;
            REG_DEMO:                  return 32'h0000_0001;
            REG_SNAC:                  return 32'h0003_031F;
            default:                   return 32'h0000_0000;
        endcase
    endfunction

    function automatic logic [31:0] snac_word(logic [4:0] ctype, logic [1:0] asg,
                                              logic ena, logic blank);
        logic [31:0] word;
        word       = '0;
        word[4:0]  = ctype;
        word[9:8]  = asg;
        word[16]   = ena;
        word[17]   = blank;
        return word;
    endfunction

    // d-pad from stick thresholds on analog pads
    function automatic logic [15:0] stick_keys(pad_t pad, logic analog);
        logic [15:0] keys;
        keys = pad.btn;
        if (analog) begin
            keys[KEY_UP]    = pad.stick[15:8] < ANALOG_LOW;
            keys[KEY_DOWN]  = pad.stick[15:8] > ANALOG_HIGH;
            keys[KEY_LEFT]  = pad.stick[7:0] < ANALOG_LOW;
            keys[KEY_RIGHT] = pad.stick[7:0] > ANALOG_HIGH;
        end
        return keys;
    endfunction

    function automatic logic [15:0] route_keys(snac_cfg_t cfg, logic [15:0] key,
                                               pad_t p1, pad_t p2);
        logic analog;
        analog = (cfg.cont_type == SNAC_ANALOG_A) || (cfg.cont_type == SNAC_ANALOG_B);
        if (cfg.cont_type == 5'h00 || !cfg.ena) begin
            return key;
        end
        case (cfg.assignment)
            2'd1:    return key;
            2'd3:    return stick_keys(p2, analog);
            default: return stick_keys(p1, analog);
        endcase
    endfunction

    function automatic int next_hold(int count, logic trig, int length);
        if (count != 0) begin
            return count - 1;
        end
        if (trig) begin
            return length;
        end
        return 0;
    endfunction

    function automatic logic [23:0] expect_rgb(video_in_t vin, snac_cfg_t cfg);
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
        r = vin.rgb12[11:8];
        g = vin.rgb12[7:4];
        b = vin.rgb12[3:0];
        if (vin.hblank || vin.vblank || (cfg.blank_screen && cfg.ena)) begin
            return 24'h0;
        end
        return {r, r, g, g, b, b};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // cycle model, inputs are stable at the edge
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk_74a) begin : model_step
        logic coin_rel;
        coin_rel = m_coin_prev & ~m_key_map[KEY_COIN];
        // colour path has no reset
        m_rgb <= expect_rgb(video_in, m_snac);
        if (reset) begin
            m_lives     <= '0;
            m_diff      <= '0;
            m_bonus     <= '0;
            m_demo      <= 1'b0;
            m_snac      <= '0;
            m_reset_req <= 1'b0;
            m_key_map   <= '0;
            m_coin_prev <= 1'b0;
            m_coin_cnt  <= 0;
            m_reset_cnt <= 0;
            m_de        <= 1'b0;
            m_hs        <= 1'b0;
            m_vs        <= 1'b0;
            m_hs_prev   <= 1'b0;
            m_vs_prev   <= 1'b0;
        end else begin
            m_reset_req <= 1'b0;
            if (apb_req.psel && apb_req.penable && apb_req.pwrite) begin
                case (apb_req.paddr)
                    REG_LIVES:      m_lives <= apb_req.pwdata[1:0];
                    REG_DIFFICULTY: m_diff  <= apb_req.pwdata[2:0];
                    REG_BONUS:      m_bonus <= apb_req.pwdata[2:0];
                    REG_DEMO:       m_demo  <= apb_req.pwdata[0];
                    REG_SNAC: begin
                        m_snac.cont_type    <= apb_req.pwdata[4:0];
                        m_snac.assignment   <= apb_req.pwdata[9:8];
                        m_snac.ena          <= apb_req.pwdata[16];
                        m_snac.blank_screen <= apb_req.pwdata[17];
                    end
                    REG_RESET:      m_reset_req <= 1'b1;
                    default: ;
                endcase
            end
            m_key_map   <= route_keys(m_snac, cont1_key, snac_p1, snac_p2);
            m_coin_prev <= m_key_map[KEY_COIN];
            m_coin_cnt  <= next_hold(m_coin_cnt, coin_rel, COIN_HOLD_CYCLES);
            m_reset_cnt <= next_hold(m_reset_cnt, m_reset_req, RESET_HOLD_CYCLES);
            m_de        <= !(video_in.hblank || video_in.vblank);
            m_hs        <= video_in.hs && !m_hs_prev;
            m_vs        <= video_in.vs && !m_vs_prev;
            m_hs_prev   <= video_in.hs;
            m_vs_prev   <= video_in.vs;
        end
    end

    // outputs compared mid cycle
    always @(negedge clk_74a) begin : compare_outputs
        controls_t  exp_ctrl;
        video_out_t exp_vid;
        exp_ctrl.up    = m_key_map[KEY_UP];
        exp_ctrl.down  = m_key_map[KEY_DOWN];
        exp_ctrl.left  = m_key_map[KEY_LEFT];
        exp_ctrl.right = m_key_map[KEY_RIGHT];
        exp_ctrl.fire  = m_key_map[KEY_FIRE];
        exp_ctrl.start = m_key_map[KEY_START];
        exp_ctrl.coin  = m_coin_cnt != 0;
        exp_vid.rgb24  = m_rgb;
        exp_vid.de     = m_de;
        exp_vid.hs     = m_hs;
        exp_vid.vs     = m_vs;
        if (checks_on) begin
            check({m_demo, 1'b0, m_lives, 6'b0, m_diff, m_bonus}, dips, "dips word");
            check(exp_ctrl, game_controls, "game controls");
            check(reset | (m_reset_cnt != 0), core_reset, "core reset");
            check(exp_vid, video_out, "video out");
            check(2'b10, {apb_rsp.pready, apb_rsp.pslverr}, "apb status");
        end
    end

    // run limit
    always @(posedge clk_74a) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////
    initial begin : stimulus
        int          i;
        int          high_cnt;
        int          first_high;
        logic [31:0] rnd;
        logic [31:0] wdata;
        logic [31:0] rdata;
        logic [7:0]  addr;
        logic [7:0]  hole;
        logic [4:0]  ctype;
        seed        = 32'h1c7a_6ff4;
        errors      = 0;
        cycle_count = 0;
        checks_on   = 1'b0;
        reset       = 1'b1;
        apb_req     = '0;
        cont1_key   = '0;
        snac_p1     = '0;
        snac_p2     = '0;
        video_in    = '0;

        // colour regs settle after two edges
        repeat (3) next_cycle();
        checks_on = 1'b1;
        repeat (5) next_cycle();
        reset = 1'b0;

        // register writes, hole writes and readback
        for (i = 0; i < N_REG; i++) begin
            addr  = pick_reg(i % 5);
            wdata = $random(seed);
            apb_write(addr, wdata);
            rnd  = $random(seed);
            hole = 8'h18 + {2'b00, rnd[5:0]};
            apb_write(hole, $random(seed));
            apb_read(addr, rdata);
            check(wdata & field_mask(addr), rdata, "register readback");
            apb_read(hole, rdata);
            check(32'h0, rdata, "unknown offset read");
        end
        apb_read(REG_RESET, rdata);
        check(32'h0, rdata, "reset register read");

        // routing, adapter off first, then each assignment
        for (i = 0; i < N_CFG; i++) begin
            rnd = $random(seed);
            case (rnd[1:0])
                2'd0:    ctype = 5'h00;
                2'd1:    ctype = SNAC_ANALOG_A;
                2'd2:    ctype = SNAC_ANALOG_B;
                default: ctype = rnd[8:4];
            endcase
            apb_write(REG_SNAC, snac_word(ctype, i[1:0], i != 0, 1'b0));
            repeat (N_PAD) begin
                rnd           = $random(seed);
                cont1_key     = rnd[15:0];
                snac_p1.btn   = rnd[31:16];
                snac_p1.stick = $random(seed);
                rnd           = $random(seed);
                snac_p2.btn   = rnd[15:0];
                snac_p2.stick = $random(seed);
                next_cycle();
            end
        end

        // coin window from console pad
        apb_write(REG_SNAC, 32'h0);
        cont1_key = '0;
        snac_p1   = '0;
        snac_p2   = '0;
        repeat (2 * COIN_HOLD_CYCLES) next_cycle();
        cont1_key[KEY_COIN] = 1'b1;
        repeat (3) next_cycle();
        cont1_key[KEY_COIN] = 1'b0;
        high_cnt   = 0;
        first_high = -1;
        for (i = 0; i < COIN_HOLD_CYCLES + 20; i++) begin
            next_cycle();
            if (game_controls.coin === 1'b1) begin
                if (first_high < 0) begin
                    first_high = i;
                end
                high_cnt++;
            end
            // second press and release lands inside the window
            cont1_key[KEY_COIN] = (high_cnt >= 4) && (high_cnt < 6);
        end
        check(1, first_high, "coin window start");
        check(COIN_HOLD_CYCLES, high_cnt, "coin window length");

        // soft reset stretch
        apb_write(REG_RESET, $random(seed));
        high_cnt   = 0;
        first_high = -1;
        for (i = 0; i < RESET_HOLD_CYCLES + 8; i++) begin
            next_cycle();
            if (core_reset === 1'b1) begin
                if (first_high < 0) begin
                    first_high = i;
                end
                high_cnt++;
            end
        end
        check(0, first_high, "soft reset start");
        check(RESET_HOLD_CYCLES, high_cnt, "soft reset length");

        // external reset drives core reset directly
        reset = 1'b1;
        repeat (3) begin
            next_cycle();
            check(1, core_reset, "core reset during reset");
        end
        reset = 1'b0;

        // video with random blank screen settings
        for (i = 0; i < N_VCFG; i++) begin
            rnd = $random(seed);
            apb_write(REG_SNAC, snac_word(rnd[4:0], rnd[9:8], rnd[16], rnd[17]));
            repeat (N_VID) begin
                rnd             = $random(seed);
                video_in.rgb12  = rnd[11:0];
                video_in.hblank = rnd[14:12] == 3'h0;
                video_in.vblank = rnd[19:16] == 4'h0;
                video_in.hs     = rnd[20];
                video_in.vs     = rnd[21];
                next_cycle();
            end
        end

        repeat (4) next_cycle();
        $display("run complete: %0d errors in %0d cycles", errors, cycle_count);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* compile.f */
source/arcade_pkg.sv
source/cfg_apb_regs.sv
source/input_router.sv
source/hold_timer.sv
source/video_formatter.sv
source/arcade_core_top.sv
testbench/tb_arcade_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the arcade glue testbench with verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    -f compile.f \
    --top-module tb_arcade_core \
    -o tb_arcade_core_sim

./obj_dir/tb_arcade_core_sim | tee "$LOG"

if grep -qx "sim passed" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL, see $LOG"
    exit 1
fi
